// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - common/rv_pkg.sv
  - hw/datapath/alu.sv
  - hw/datapath/regfile.sv
  - hw/datapath/control_transfer.sv
  - hw/datapath/singlecycle_datapath.sv
  - hw/rv_control.sv
  - hw/rv_core.sv
  - target: test
    files:
      - bench/core_checker.sv
      - bench/core_monitor.sv
      - bench/tb_core.sv

// ==== all.f ====
common/rv_pkg.sv
hw/datapath/alu.sv
hw/datapath/regfile.sv
hw/datapath/control_transfer.sv
hw/datapath/singlecycle_datapath.sv
hw/rv_control.sv
hw/rv_core.sv
bench/core_checker.sv
bench/core_monitor.sv
bench/tb_core.sv

// ==== bench/core_checker.sv ====
// port assertions for rv_core attached with bind
// the store enable must stay low whenever run is low
`timescale 1ns/1ps
`default_nettype none

module core_checker (
    input wire logic                    clock,
    input wire logic                    arst_n,
    input wire logic                    run,
    input wire logic [rv_pkg::XLEN-1:0] pc,
    input wire rv_pkg::dmem_req_t       dmem_req
);
    import rv_pkg::*;

    int failures = 0;

    reset_pc: assert property (@(posedge clock) $rose(arst_n) |-> pc == RESET_PC)
        else begin
            failures++;
            $error("pc is not at the reset address in the first cycle after reset");
        end

    no_store_in_reset: assert property (@(posedge clock) !arst_n |-> !dmem_req.we)
        else begin
            failures++;
            $error("store enable is high while reset is asserted");
        end

    // stalled cycle keeps pc and issues no store
    stall_holds_pc: assert property (
        @(posedge clock) disable iff (!arst_n) !run |=> pc == $past(pc))
        else begin
            failures++;
            $error("pc moved after a cycle with run low");
        end

    no_store_stalled: assert property (
        @(posedge clock) disable iff (!arst_n) !run |-> !dmem_req.we)
        else begin
            failures++;
            $error("store enable is high while run is low");
        end

endmodule

`default_nettype wire

// ==== bench/core_monitor.sv ====
// RV32I reference model that steps on every edge with run high
// covers only the instructions that the random program uses with word memory access
`timescale 1ns/1ps
`default_nettype none

module core_monitor (
    input  wire logic              clock,
    input  wire logic              arst_n,
    input  wire logic              run,
    input  wire logic [31:0]       pc,
    input  wire rv_pkg::dmem_req_t dmem_req,
    output logic                   done,
    output int                     checks,
    output int                     errors
);
    localparam logic [31:0] END_PC = 32'd1020;
    localparam logic [31:0] DUMP_PC = 32'd896;

    // loaded by the testbench before reset ends
    logic [31:0] prog [0:255];
    logic [31:0] data_init [0:63];

    logic [31:0] mem [0:63];
    logic [31:0] regs [0:31];
    logic [31:0] model_pc;
    int          test_checks [3];
    int          test_errors [3];
    string       test_names [3] = '{"pc_trace", "memory", "register_dump"};

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a, b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] reference_alu(input logic [2:0] f3, input logic alt,
                                                  input logic [31:0] a, b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic compare_word(input int t, input logic [31:0] expected, actual);
        test_checks[t]++;
        if (expected !== actual) begin
            test_errors[t]++;
            $display("Fail %s at pc %h expected %h actual %h",
                     test_names[t], model_pc, expected, actual);
        end
    endtask

    task automatic step_model();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] ea;
        logic [31:0] res;
        logic [31:0] nxt;
        logic        wr;
        int          t;
        ins = prog[model_pc[9:2]];
        a = regs[ins[19:15]];
        b = regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        res = '0;
        nxt = model_pc + 32'd4;
        wr = 1'b1;
        t = (model_pc >= DUMP_PC) ? 2 : 1;
        if (ins[6:0] != 7'b0100011 && dmem_req.we) begin
            test_errors[1]++;
            $display("unexpected store issued at pc %h", model_pc);
        end
        case (ins[6:0])
            7'b0110111: res = {ins[31:12], 12'b0};
            7'b0010111: res = model_pc + {ins[31:12], 12'b0};
            7'b1101111: begin
                res = model_pc + 32'd4;
                nxt = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'b1100111: begin
                res = model_pc + 32'd4;
                nxt = (a + imm_i) & ~32'd1;
            end
            7'b1100011: begin
                wr = 1'b0;
                if (branch_taken(ins[14:12], a, b)) begin
                    nxt = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'b0000011: begin
                ea = a + imm_i;
                compare_word(t, ea, dmem_req.addr);
                res = mem[ea[7:2]];
            end
            7'b0100011: begin
                wr = 1'b0;
                ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                if (!dmem_req.we) begin
                    test_errors[t]++;
                    $display("store at pc %h was not issued", model_pc);
                end
                compare_word(t, ea, dmem_req.addr);
                compare_word(t, b, dmem_req.wdata);
                mem[ea[7:2]] = b;
            end
            7'b0010011: res = reference_alu(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
            7'b0110011: res = reference_alu(ins[14:12], ins[30], a, b);
            default:    wr = 1'b0;
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            regs[ins[11:7]] = res;
        end
        model_pc = nxt;
    endtask

    task automatic report_tests();
        checks = 0;
        errors = 0;
        for (int t = 0; t < 3; t++) begin
            $display("%s %0d checks, %0d errors", test_names[t], test_checks[t],
                     test_errors[t]);
            checks += test_checks[t];
            errors += test_errors[t];
        end
    endtask

    always @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            model_pc = 32'd0;
            done = 1'b0;
            checks = 0;
            errors = 0;
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            for (int i = 0; i < 64; i++) begin
                mem[i] = data_init[i];
            end
            for (int t = 0; t < 3; t++) begin
                test_checks[t] = 0;
                test_errors[t] = 0;
            end
        end else if (run && !done) begin
            compare_word(0, model_pc, pc);
            if (model_pc == END_PC) begin
                report_tests();
                done = 1'b1;
            end else begin
                step_model();
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_core.sv ====
// testbench for rv_core with a seeded random program and a 64-word data memory
// program runs forward only and then dumps x1..x31 before a final self-jump
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import rv_pkg::*;

    localparam int CYCLE_LIMIT = 256 * 2 + 64;
    localparam int DUMP_INDEX = 224;

    logic            clock;
    logic            arst_n;
    logic            run;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] dmem_rdata;
    dmem_req_t       dmem_req;
    logic [31:0]     imem [0:255];
    logic [31:0]     dmem [0:63];
    logic            run_pattern [0:CYCLE_LIMIT-1];
    logic            done;
    int              checks;
    int              errors;
    int              cycles = 0;

    rv_core rv_core_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .run        (run),
        .pc         (pc),
        .instr      (instr),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    core_monitor core_monitor_inst (
        .clock    (clock),
        .arst_n   (arst_n),
        .run      (run),
        .pc       (pc),
        .dmem_req (dmem_req),
        .done     (done),
        .checks   (checks),
        .errors   (errors)
    );

    bind rv_core core_checker core_checker_inst (
        .clock    (clock),
        .arst_n   (arst_n),
        .run      (run),
        .pc       (pc),
        .dmem_req (dmem_req)
    );

    assign instr = imem[pc[9:2]];
    assign dmem_rdata = dmem[dmem_req.addr[7:2]];

    always #50 clock = ~clock;

    always @(posedge clock) begin
        if (dmem_req.we) begin
            dmem[dmem_req.addr[7:2]] <= dmem_req.wdata;
        end
        if (arst_n) begin
            cycles <= cycles + 1;
            run <= run_pattern[cycles % CYCLE_LIMIT];
        end
    end

    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [11:0] ofs);
        return {ofs[11:5], rs2, 5'd0, 3'b010, ofs[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] random_instr(input int idx);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [20:0] off;
        int          span;
        int          kind;
        rd = 5'($urandom);
        rs1 = 5'($urandom);
        rs2 = 5'($urandom);
        f3 = 3'($urandom);
        f7 = $urandom_range(0, 1) ? 7'h20 : 7'h00;
        // forward targets never pass the register dump
        span = (DUMP_INDEX - idx > 8) ? 8 : DUMP_INDEX - idx;
        off = 21'(4 * $urandom_range(1, span));
        kind = $urandom_range(0, 9);
        case (kind)
            0: return {20'($urandom), rd, 7'b0110111};
            1: return {20'($urandom), rd, 7'b0010111};
            2, 3: begin
                if (f3 != 3'b000 && f3 != 3'b101) begin
                    f7 = 7'h00;
                end
                return {f7, rs2, rs1, f3, rd, 7'b0110011};
            end
            4, 5: begin
                if (f3 == 3'b001) begin
                    imm = {7'h00, rs2};
                end else if (f3 == 3'b101) begin
                    imm = {f7, rs2};
                end else begin
                    imm = 12'($urandom);
                end
                return {imm, rs1, f3, rd, 7'b0010011};
            end
            6: return {12'(4 * $urandom_range(0, 63)), 5'd0, 3'b010, rd, 7'b0000011};
            7: return store_word(rs2, 12'(4 * $urandom_range(0, 63)));
            8: begin
                span = $urandom_range(0, 5);
                f3 = (span < 2) ? 3'(span) : 3'(span + 2);
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
            end
            default: begin
                if ($urandom_range(0, 1) == 1) begin
                    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
                end
                // absolute target from x0 with bit 0 sometimes set
                imm = 12'(idx * 4 + int'(off)) | 12'($urandom_range(0, 1));
                return {imm, 5'd0, 3'b000, rd, 7'b1100111};
            end
        endcase
    endfunction

    initial begin
        int total;
        void'($urandom(67));
        clock = 1'b0;
        arst_n = 1'b0;
        run = 1'b0;
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $urandom;
            core_monitor_inst.data_init[i] = dmem[i];
        end
        for (int i = 0; i < DUMP_INDEX; i++) begin
            imem[i] = random_instr(i);
        end
        for (int j = 0; j < 31; j++) begin
            imem[DUMP_INDEX + j] = store_word(5'(j + 1), 12'(j * 4));
        end
        // jal x0, 0
        imem[255] = 32'h0000_006f;
        for (int i = 0; i < 256; i++) begin
            core_monitor_inst.prog[i] = imem[i];
        end
        // run low about one cycle in five
        for (int i = 0; i < CYCLE_LIMIT; i++) begin
            run_pattern[i] = ($urandom_range(0, 9) >= 2);
        end

        repeat (3) @(posedge clock);
        arst_n <= 1'b1;

        wait (done || cycles >= CYCLE_LIMIT);
        @(negedge clock);
        total = errors + rv_core_inst.core_checker_inst.failures;
        if (!done) begin
            $display("program never reached its final jump within %0d cycles", CYCLE_LIMIT);
        end else begin
            $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                     rv_core_inst.core_checker_inst.failures);
        end
        if (done && total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== common/rv_pkg.sv ====
// shared definitions for the single-cycle RV32I core
// only the opcodes listed in opcode_e are decoded, all others act as a no-op
`default_nettype none

package rv_pkg;

    localparam int XLEN = 32;
    localparam int REG_AW = 5;
    localparam logic [XLEN-1:0] RESET_PC = '0;

    // instruction field positions
    localparam int OPCODE_MSB = 6;
    localparam int OPCODE_LSB = 0;
    localparam int RD_MSB = 11;
    localparam int RD_LSB = 7;
    localparam int FUNCT3_MSB = 14;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_MSB = 19;
    localparam int RS1_LSB = 15;
    localparam int RS2_MSB = 24;
    localparam int RS2_LSB = 20;
    // funct7 bit 5, selects SUB and SRA
    localparam int FUNCT7_ALT_BIT = 30;

    // branch funct3 codes
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // next-pc select codes
    localparam logic [1:0] NPC_SEQ = 2'd0;
    localparam logic [1:0] NPC_REL = 2'd1;
    localparam logic [1:0] NPC_REG = 2'd2;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_OP_ADD,
        ALU_OP_BRANCH,
        ALU_OP_REG,
        ALU_OP_IMM,
        ALU_OP_PASS_B
    } alu_op_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_fn_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_LOAD,
        WB_PC4,
        WB_IMM
    } wb_sel_e;

    typedef struct packed {
        logic    reg_write;
        logic    a_sel_pc;
        logic    b_sel_imm;
        logic    jal;
        logic    jalr;
        logic    branch;
        logic    mem_write;
        alu_op_e alu_op;
        wb_sel_e wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            we;
    } dmem_req_t;

    // all enables low, falls through to pc + 4
    localparam ctrl_t CTRL_NOP = '{
        reg_write: 1'b0,
        a_sel_pc:  1'b0,
        b_sel_imm: 1'b0,
        jal:       1'b0,
        jalr:      1'b0,
        branch:    1'b0,
        mem_write: 1'b0,
        alu_op:    ALU_OP_ADD,
        wb_sel:    WB_ALU
    };

endpackage

`default_nettype wire

// ==== hw/datapath/alu.sv ====
// ALU decode and ALU, combinational
// shifts use the low 5 bits of operand_b
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_pkg::alu_op_e         alu_op,
    input  wire logic [2:0]              funct3,
    input  wire logic                    funct7_bit,
    input  wire logic [rv_pkg::XLEN-1:0] operand_a,
    input  wire logic [rv_pkg::XLEN-1:0] operand_b,
    output logic [rv_pkg::XLEN-1:0]      result,
    output logic                         result_zero,
    output logic                         less
);
    import rv_pkg::*;

    alu_fn_e alu_fn;
    logic    lt_signed;
    logic    lt_unsigned;

    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;

    always_comb begin
        case (alu_op)
            ALU_OP_BRANCH: alu_fn = ALU_SUB;
            ALU_OP_PASS_B: alu_fn = ALU_PASS_B;
            ALU_OP_REG, ALU_OP_IMM: begin
                case (funct3)
                    // immediates have no SUBI
                    3'b000:  alu_fn = (funct7_bit && alu_op == ALU_OP_REG) ? ALU_SUB : ALU_ADD;
                    3'b001:  alu_fn = ALU_SLL;
                    3'b010:  alu_fn = ALU_SLT;
                    3'b011:  alu_fn = ALU_SLTU;
                    3'b100:  alu_fn = ALU_XOR;
                    3'b101:  alu_fn = funct7_bit ? ALU_SRA : ALU_SRL;
                    3'b110:  alu_fn = ALU_OR;
                    default: alu_fn = ALU_AND;
                endcase
            end
            default: alu_fn = ALU_ADD;
        endcase
    end

    always_comb begin
        case (alu_fn)
            ALU_SUB:    result = operand_a - operand_b;
            ALU_SLL:    result = operand_a << operand_b[4:0];
            ALU_SLT:    result = XLEN'(lt_signed);
            ALU_SLTU:   result = XLEN'(lt_unsigned);
            ALU_XOR:    result = operand_a ^ operand_b;
            ALU_SRL:    result = operand_a >> operand_b[4:0];
            ALU_SRA:    result = XLEN'($signed(operand_a) >>> operand_b[4:0]);
            ALU_OR:     result = operand_a | operand_b;
            ALU_AND:    result = operand_a & operand_b;
            ALU_PASS_B: result = operand_b;
            default:    result = operand_a + operand_b;
        endcase
    end

    assign result_zero = (result == '0);
    // funct3 bit 1 marks BLTU/BGEU
    assign less = funct3[1] ? lt_unsigned : lt_signed;

endmodule

`default_nettype wire

// ==== hw/datapath/control_transfer.sv ====
// branch resolution and next-pc source, combinational
// less comes from the ALU, signed or unsigned by funct3
`timescale 1ns/1ps
`default_nettype none

module control_transfer (
    input  wire logic       branch,
    input  wire logic       jal,
    input  wire logic       jalr,
    input  wire logic [2:0] funct3,
    input  wire logic       result_zero,
    input  wire logic       less,
    output logic [1:0]      next_pc_select
);
    import rv_pkg::*;

    logic taken;

    always_comb begin
        case (funct3)
            F3_BEQ:          taken = result_zero;
            F3_BNE:          taken = !result_zero;
            F3_BLT, F3_BLTU: taken = less;
            F3_BGE, F3_BGEU: taken = !less;
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        if (jalr) begin
            next_pc_select = NPC_REG;
        end else if (jal || (branch && taken)) begin
            next_pc_select = NPC_REL;
        end else begin
            next_pc_select = NPC_SEQ;
        end
    end

endmodule

`default_nettype wire

// ==== hw/datapath/regfile.sv ====
// x1..x31 with asynchronous read, x0 reads as zero
// a write is visible from the next cycle on
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  wire logic                      clock,
    input  wire logic                      arst_n,
    input  wire logic                      write_enable,
    input  wire logic [rv_pkg::REG_AW-1:0] rd_address,
    input  wire logic [rv_pkg::REG_AW-1:0] rs1_address,
    input  wire logic [rv_pkg::REG_AW-1:0] rs2_address,
    input  wire logic [rv_pkg::XLEN-1:0]   rd_data,
    output logic [rv_pkg::XLEN-1:0]        rs1_data,
    output logic [rv_pkg::XLEN-1:0]        rs2_data
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd_address != '0) begin
            regs[rd_address] <= rd_data;
        end
    end

    assign rs1_data = (rs1_address == '0) ? '0 : regs[rs1_address];
    assign rs2_data = (rs2_address == '0) ? '0 : regs[rs2_address];

endmodule

`default_nettype wire

// ==== hw/datapath/singlecycle_datapath.sv ====
// single-cycle datapath, one instruction per rising edge while run is high
// memories are combinational, the store commits at the edge ending the cycle
// no bypass inside the register file
`timescale 1ns/1ps
`default_nettype none

module singlecycle_datapath (
    input  wire logic                    clock,
    input  wire logic                    arst_n,
    input  wire logic                    run,
    input  wire logic [rv_pkg::XLEN-1:0] instr,
    input  wire rv_pkg::ctrl_t           ctrl,
    input  wire logic [rv_pkg::XLEN-1:0] imm,
    output logic [rv_pkg::XLEN-1:0]      pc,
    output rv_pkg::dmem_req_t            dmem_req,
    input  wire logic [rv_pkg::XLEN-1:0] dmem_rdata
);
    import rv_pkg::*;

    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] rd_data;
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;
    logic            result_zero;
    logic            less;
    logic [XLEN-1:0] pc_plus_4;
    logic [XLEN-1:0] pc_plus_imm;
    logic [XLEN-1:0] next_pc;
    logic [1:0]      next_pc_select;

    assign pc_plus_4   = pc + XLEN'(4);
    assign pc_plus_imm = pc + imm;

    assign operand_a = ctrl.a_sel_pc ? pc : rs1_data;
    assign operand_b = ctrl.b_sel_imm ? imm : rs2_data;

    always_comb begin
        case (ctrl.wb_sel)
            WB_LOAD: rd_data = dmem_rdata;
            WB_PC4:  rd_data = pc_plus_4;
            WB_IMM:  rd_data = imm;
            default: rd_data = alu_result;
        endcase
    end

    always_comb begin
        case (next_pc_select)
            NPC_REL: next_pc = pc_plus_imm;
            // jalr target has bit 0 cleared
            NPC_REG: next_pc = {alu_result[XLEN-1:1], 1'b0};
            default: next_pc = pc_plus_4;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (run) begin
            pc <= next_pc;
        end
    end

    assign dmem_req.addr  = alu_result;
    assign dmem_req.wdata = rs2_data;
    assign dmem_req.we    = ctrl.mem_write & run;

    alu alu_inst (
        .alu_op      (ctrl.alu_op),
        .funct3      (instr[FUNCT3_MSB:FUNCT3_LSB]),
        .funct7_bit  (instr[FUNCT7_ALT_BIT]),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .result      (alu_result),
        .result_zero (result_zero),
        .less        (less)
    );

    regfile regfile_inst (
        .clock        (clock),
        .arst_n       (arst_n),
        .write_enable (ctrl.reg_write & run),
        .rd_address   (instr[RD_MSB:RD_LSB]),
        .rs1_address  (instr[RS1_MSB:RS1_LSB]),
        .rs2_address  (instr[RS2_MSB:RS2_LSB]),
        .rd_data      (rd_data),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

    control_transfer control_transfer_inst (
        .branch         (ctrl.branch),
        .jal            (ctrl.jal),
        .jalr           (ctrl.jalr),
        .funct3         (instr[FUNCT3_MSB:FUNCT3_LSB]),
        .result_zero    (result_zero),
        .less           (less),
        .next_pc_select (next_pc_select)
    );

endmodule

`default_nettype wire

// ==== hw/rv_control.sv ====
// main decoder, combinational
// word loads and stores only, funct3 of LOAD/STORE is not checked
`timescale 1ns/1ps
`default_nettype none

module rv_control (
    input  wire logic [rv_pkg::XLEN-1:0] instr,
    output rv_pkg::ctrl_t                ctrl,
    output logic [rv_pkg::XLEN-1:0]      imm
);
    import rv_pkg::*;

    opcode_e opcode;

    assign opcode = opcode_e'(instr[OPCODE_MSB:OPCODE_LSB]);

    always_comb begin
        ctrl = CTRL_NOP;
        imm  = '0;
        case (opcode)
            OPC_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.alu_op    = ALU_OP_PASS_B;
                ctrl.wb_sel    = WB_IMM;
                imm            = {instr[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.a_sel_pc  = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                imm            = {instr[31:12], 12'b0};
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jal       = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OPC_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_OP_BRANCH;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OPC_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.wb_sel    = WB_LOAD;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            OPC_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.alu_op    = ALU_OP_IMM;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            OPC_OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_OP_REG;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
// single-cycle RV32I core top
// instruction and data memories answer combinationally in the same cycle
// run low holds pc and registers and blocks stores
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire logic                    clock,
    input  wire logic                    arst_n,
    input  wire logic                    run,
    output logic [rv_pkg::XLEN-1:0]      pc,
    input  wire logic [rv_pkg::XLEN-1:0] instr,
    output rv_pkg::dmem_req_t            dmem_req,
    input  wire logic [rv_pkg::XLEN-1:0] dmem_rdata
);
    import rv_pkg::*;

    ctrl_t           ctrl;
    logic [XLEN-1:0] imm;

    rv_control rv_control_inst (
        .instr (instr),
        .ctrl  (ctrl),
        .imm   (imm)
    );

    singlecycle_datapath singlecycle_datapath_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .run        (run),
        .instr      (instr),
        .ctrl       (ctrl),
        .imm        (imm),
        .pc         (pc),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

endmodule

`default_nettype wire
